/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal
TOP       := rvCoreTb
FILELIST  := filelist.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* filelist.f */
source/rvPkg.sv
source/instDecoder.sv
source/aluExecute.sv
source/resultSelect.sv
source/regFile.sv
source/coreSequencer.sv
source/rvCore.sv
sim/tbClock.sv
sim/rvCore_checker.sv
sim/rvCoreTb.sv

/* sim/rvCoreTb.sv */
`timescale 1ns/1ps

module rvCoreTb import rvPkg::*; ();

    localparam int dataBase   = 64;  // doubleword index of 0x200
    localparam int patternIdx = 96;  // 0x300
    localparam int poisonSlot = 31;
    localparam int maxCyclesPerInst = 16;

    logic    clock;
    logic    rstN;
    logic    wbCyc;
    logic    wbStb;
    logic    wbWe;
    addrT    wbAdr;
    xlenT    wbDatW;
    xlenT    wbDatR;
    byteSelT wbSel;
    logic    wbAck;
    logic    halted;

    xlenT       mem [128];
    xlenT       expectVal [32];
    logic       used [32];
    logic       stored [32];
    string      testName [32];
    int         pcw;
    int         seed = 51;
    int         randVal;
    logic [1:0] waitCnt;
    int         passCount;
    int         storeFails;
    int         endFails;
    int         cycles;
    int         limit;
    int         jalAddr;
    int         jalrAddr;

    tbClock clockGen (.clock(clock), .rstN(rstN));

    rvCore DUT (
        .clock  (clock),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbSel  (wbSel),
        .wbAck  (wbAck),
        .halted (halted)
    );

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[pcw >> 1][32*(pcw & 1) +: 32] = word;
        pcw++;
    endtask

    // sd rs, slot*8(x10) and record what the slot must hold
    task automatic storeResult(input logic [4:0] rs, input int slot, input xlenT value,
            input string name);
        emit(sType(12'(slot * 8), rs, 5'd10, 3'd3));
        expectVal[slot] = value;
        used[slot]      = 1'b1;
        testName[slot]  = name;
    endtask

    task automatic emitPoison();
        emit(sType(12'(poisonSlot * 8), 5'd0, 5'd10, 3'd3));  // must be skipped
    endtask

    task automatic checkStore(input int idx);
        int slot;
        for (int b = 0; b < 8; b++) begin
            if (wbSel[b]) begin
                mem[idx][8*b +: 8] = wbDatW[8*b +: 8];
            end
        end
        slot = idx - dataBase;
        if (slot < 0 || slot > 31 || !used[slot]) begin
            $display("FAIL: store to 0x%h that no test expects (skipped code ran?)", wbAdr);
            storeFails++;
        end else begin
            stored[slot] = 1'b1;
            assert (mem[idx] == expectVal[slot]) begin
                passCount++;
                $display("test %0d %s: ok", slot, testName[slot]);
            end else begin
                $display("FAIL %0t mem[0x%h] (%s) expected 0x%h got 0x%h", $time, wbAdr,
                         testName[slot], expectVal[slot], mem[idx]);
                storeFails++;
            end
        end
    endtask

    // slave with random wait states
    always @(posedge clock) begin
        if (!rstN) begin
            wbAck   <= 1'b0;
            waitCnt <= 2'd0;
        end else if (wbAck) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (waitCnt == 2'd0) begin
                wbAck   <= 1'b1;
                randVal = $random(seed);
                waitCnt <= randVal[1:0];
                if (wbWe) begin
                    checkStore(int'(wbAdr[9:3]));
                end else begin
                    wbDatR <= mem[wbAdr[9:3]];
                end
            end else begin
                waitCnt <= waitCnt - 2'd1;
            end
        end
    end

    task automatic buildProgram();
        pcw = 0;
        emit(iType(12'h200, 5'd0, 3'd0, 5'd10, 7'b0010011));  // x10 = store base
        emit(iType(-12'sd7, 5'd0, 3'd0, 5'd1, 7'b0010011));   // x1 = -7
        emit(iType(12'd3, 5'd0, 3'd0, 5'd2, 7'b0010011));     // x2 = 3
        emit({20'h80000, 5'd3, 7'b0110111});                  // lui x3
        emit(iType(12'd30, 5'd0, 3'd0, 5'd7, 7'b0010011));
        emit(iType(12'h300, 5'd0, 3'd0, 5'd11, 7'b0010011));  // x11 = pattern
        emit(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd5, 7'b0110011));
        storeResult(5'd5, 0, -64'sd4, "add");
        emit(rType(7'h20, 5'd1, 5'd2, 3'd0, 5'd5, 7'b0110011));
        storeResult(5'd5, 1, 64'd10, "sub");
        emit(rType(7'h00, 5'd2, 5'd1, 3'd1, 5'd5, 7'b0110011));
        storeResult(5'd5, 2, 64'hFFFF_FFFF_FFFF_FFC8, "sll");
        emit(rType(7'h00, 5'd2, 5'd1, 3'd5, 5'd5, 7'b0110011));
        storeResult(5'd5, 3, 64'h1FFF_FFFF_FFFF_FFFF, "srl");
        emit(rType(7'h20, 5'd2, 5'd1, 3'd5, 5'd5, 7'b0110011));
        storeResult(5'd5, 4, '1, "sra");
        emit(rType(7'h00, 5'd2, 5'd1, 3'd2, 5'd5, 7'b0110011));
        storeResult(5'd5, 5, 64'd1, "slt");
        emit(rType(7'h00, 5'd1, 5'd2, 3'd3, 5'd5, 7'b0110011));
        storeResult(5'd5, 6, 64'd1, "sltu");
        emit(rType(7'h00, 5'd3, 5'd1, 3'd4, 5'd5, 7'b0110011));  // xor
        emit(iType(12'h0f0, 5'd5, 3'd7, 5'd5, 7'b0010011));       // andi
        emit(rType(7'h00, 5'd2, 5'd5, 3'd6, 5'd5, 7'b0110011));  // or
        storeResult(5'd5, 7, 64'hF3, "xor/and/or");
        storeResult(5'd3, 9, 64'hFFFF_FFFF_8000_0000, "lui");
        emit({20'h00001, 5'd5, 7'b0010111});
        storeResult(5'd5, 8, 64'(4 * (pcw - 1) + 'h1000), "auipc");
        emit(iType(-12'sd1, 5'd3, 3'd0, 5'd5, 7'b0011011));       // addiw
        emit(rType(7'h00, 5'd2, 5'd5, 3'd0, 5'd5, 7'b0111011));  // addw
        storeResult(5'd5, 10, 64'hFFFF_FFFF_8000_0002, "addiw/addw");
        emit(rType(7'h20, 5'd3, 5'd2, 3'd0, 5'd5, 7'b0111011));
        storeResult(5'd5, 11, 64'hFFFF_FFFF_8000_0003, "subw");
        emit(rType(7'h00, 5'd7, 5'd2, 3'd1, 5'd5, 7'b0111011));
        storeResult(5'd5, 12, 64'hFFFF_FFFF_C000_0000, "sllw");
        emit(rType(7'h00, 5'd2, 5'd3, 3'd5, 5'd5, 7'b0111011));
        storeResult(5'd5, 13, 64'h1000_0000, "srlw");
        emit(rType(7'h20, 5'd2, 5'd3, 3'd5, 5'd5, 7'b0111011));
        storeResult(5'd5, 14, 64'hFFFF_FFFF_F000_0000, "sraw");
        emit(iType(12'd3, 5'd11, 3'd0, 5'd5, 7'b0000011));
        storeResult(5'd5, 15, 64'hFFFF_FFFF_FFFF_FF85, "lb");
        emit(iType(12'd6, 5'd11, 3'd1, 5'd5, 7'b0000011));
        storeResult(5'd5, 16, 64'hFFFF_FFFF_FFFF_F1E2, "lh");
        emit(iType(12'd0, 5'd11, 3'd2, 5'd5, 7'b0000011));
        storeResult(5'd5, 17, 64'hFFFF_FFFF_85A6_1778, "lw");
        emit(iType(12'd0, 5'd11, 3'd3, 5'd5, 7'b0000011));
        storeResult(5'd5, 18, 64'hF1E2_D3C4_85A6_1778, "ld");
        emit(iType(12'd4, 5'd11, 3'd4, 5'd5, 7'b0000011));
        storeResult(5'd5, 19, 64'hC4, "lbu");
        emit(iType(12'd2, 5'd11, 3'd5, 5'd5, 7'b0000011));
        storeResult(5'd5, 20, 64'h85A6, "lhu");
        emit(iType(12'd4, 5'd11, 3'd6, 5'd5, 7'b0000011));
        storeResult(5'd5, 21, 64'hF1E2_D3C4, "lwu");
        emit(sType(12'd179, 5'd1, 5'd10, 3'd0));  // sb at byte 3 of slot 22
        expectVal[22] = 64'hF900_0000;
        used[22]      = 1'b1;
        testName[22]  = "sb";
        emit(sType(12'd186, 5'd1, 5'd10, 3'd1));
        expectVal[23] = 64'hFFF9_0000;
        used[23]      = 1'b1;
        testName[23]  = "sh";
        emit(sType(12'd196, 5'd5, 5'd10, 3'd2));
        expectVal[24] = 64'hF1E2_D3C4_0000_0000;
        used[24]      = 1'b1;
        testName[24]  = "sw";
        emit(iType(12'd0, 5'd0, 3'd0, 5'd5, 7'b0010011));
        emit(bType(13'd8, 5'd2, 5'd1, 3'd0));                 // beq, not taken
        emit(iType(12'd1, 5'd5, 3'd0, 5'd5, 7'b0010011));
        emit(bType(13'd8, 5'd2, 5'd1, 3'd1));                 // bne, taken
        emitPoison();
        emit(bType(13'd8, 5'd2, 5'd1, 3'd4));                 // blt, taken
        emitPoison();
        emit(bType(13'd8, 5'd2, 5'd1, 3'd5));                 // bge, not taken
        emit(iType(12'd2, 5'd5, 3'd0, 5'd5, 7'b0010011));
        emit(bType(13'd8, 5'd1, 5'd2, 3'd6));                 // bltu, taken
        emitPoison();
        emit(bType(13'd8, 5'd1, 5'd2, 3'd7));                 // bgeu, not taken
        emit(iType(12'd4, 5'd5, 3'd0, 5'd5, 7'b0010011));
        storeResult(5'd5, 25, 64'd7, "branches");
        jalAddr = 4 * pcw;
        emit(jType(21'd8, 5'd6));
        emitPoison();
        storeResult(5'd6, 26, 64'(jalAddr + 4), "jal");
        jalrAddr = 4 * pcw;
        emit({20'h00000, 5'd8, 7'b0010111});                  // auipc x8, 0
        emit(iType(12'd13, 5'd8, 3'd0, 5'd9, 7'b1100111));    // odd target, bit 0 cleared
        emitPoison();
        storeResult(5'd9, 27, 64'(jalrAddr + 8), "jalr");
        emit(32'h0010_0073);  // ebreak
    endtask

    initial begin
        wbAck      = 1'b0;
        wbDatR     = '0;
        waitCnt    = 2'd0;
        passCount  = 0;
        storeFails = 0;
        endFails   = 0;
        for (int i = 0; i < 128; i++) begin
            mem[i] = {8{8'(i) ^ 8'hA5}};
        end
        for (int i = 0; i < 32; i++) begin
            mem[dataBase + i] = '0;
            used[i]           = 1'b0;
            stored[i]         = 1'b0;
            expectVal[i]      = '0;
            testName[i]       = "";
        end
        mem[patternIdx] = 64'hF1E2_D3C4_85A6_1778;
        buildProgram();
        limit = pcw * maxCyclesPerInst + 50;

        wait (rstN);
        cycles = 0;
        while (halted !== 1'b1 && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("timeout: core did not halt within %0d cycles", limit);
            endFails++;
        end
        repeat (4) @(posedge clock);  // halt must hold with the bus idle
        for (int i = 0; i < 32; i++) begin
            if (used[i] && !stored[i]) begin
                $display("test %0d %s never stored its result", i, testName[i]);
                endFails++;
            end
        end
        $display("tests passed %0d, failed %0d, other errors %0d, checker errors %0d",
                 passCount, storeFails, endFails, DUT.checks.failCount);
        if (storeFails == 0 && endFails == 0 && DUT.checks.failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sim/rvCore_checker.sv */
`timescale 1ns/1ps

module rvCore_checker import rvPkg::*; (
    input logic    clock,
    input logic    rstN,
    input logic    wbCyc,
    input logic    wbStb,
    input logic    wbWe,
    input addrT    wbAdr,
    input xlenT    wbDatW,
    input byteSelT wbSel,
    input logic    wbAck,
    input logic    halted,
    input instT    inst,
    input ctrlT    ctrl,
    input xlenT    aluResult,
    input xlenT    rs2Val
);

    int failCount = 0;

    // each enabled lane b carries source byte b - offset, and only those lanes are enabled
    function automatic logic storeLanesMatch(input logic [1:0] size, input logic [2:0] offset,
            input byteSelT sel, input xlenT data, input xlenT src);
        int first;
        int last;
        first = int'(offset);
        last  = first + (1 << size) - 1;
        for (int b = 0; b < 8; b++) begin
            if (sel[b] != (b >= first && b <= last)) begin
                return 1'b0;
            end
            if (sel[b] && data[8*b +: 8] != src[8*(b - first) +: 8]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    stbNeedsCyc: assert property (@(posedge clock) disable iff (!rstN) wbStb |-> wbCyc)
        else begin $error("wbStb high without wbCyc"); failCount++; end

    holdUntilAck: assert property (@(posedge clock) disable iff (!rstN)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbSel)
                            && (!wbWe || $stable(wbDatW)))
        else begin $error("bus request changed before ack"); failCount++; end

    dropOnAck: assert property (@(posedge clock) disable iff (!rstN) wbStb && wbAck |=> !wbStb)
        else begin $error("wbStb still high after ack"); failCount++; end

    // store size from funct3 of the instruction word
    storeLanes: assert property (@(posedge clock) disable iff (!rstN)
        wbStb && wbWe |-> storeLanesMatch(inst[13:12], aluResult[2:0], wbSel, wbDatW, rs2Val))
        else begin $error("store selects or lane data wrong"); failCount++; end

    haltStays: assert property (@(posedge clock) disable iff (!rstN)
        halted |=> halted && !wbCyc && !wbStb)
        else begin $error("bus activity or halt drop after ebreak"); failCount++; end

    haltFromEbreak: assert property (@(posedge clock) disable iff (!rstN)
        $rose(halted) |-> $past(ctrl.halt))
        else begin $error("halted rose without ebreak"); failCount++; end

endmodule

bind rvCore rvCore_checker checks (.*);

/* sim/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clock,
    output logic rstN
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clock);
        rstN <= 1'b1;
    end

endmodule

/* source/aluExecute.sv */
`timescale 1ns/1ps

module aluExecute import rvPkg::*; (
    input  ctrlT ctrl,
    input  addrT pc,
    input  xlenT imm,
    input  xlenT rs1Val,
    input  xlenT rs2Val,
    output xlenT aluResult,
    output addrT nextPc
);

    xlenT       opA;
    xlenT       opB;
    xlenT       shiftSrc;
    logic [5:0] shamt;

    assign opA   = (ctrl.selA == selPc) ? pc : rs1Val;
    assign opB   = (ctrl.selB == selImm) ? imm : rs2Val;
    assign shamt = ctrl.word32 ? {1'b0, opB[4:0]} : opB[5:0];

    // W right shifts see only the low word of rs1
    always_comb begin
        shiftSrc = opA;
        if (ctrl.word32) begin
            if (ctrl.aluOp == aluSra) begin
                shiftSrc = {{32{opA[31]}}, opA[31:0]};
            end else begin
                shiftSrc = {32'b0, opA[31:0]};
            end
        end
    end

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluSll:   aluResult = shiftSrc << shamt;
            aluSlt:   aluResult = {63'b0, $signed(opA) < $signed(opB)};
            aluSltu:  aluResult = {63'b0, opA < opB};
            aluXor:   aluResult = opA ^ opB;
            aluSrl:   aluResult = shiftSrc >> shamt;
            aluSra:   aluResult = $signed(shiftSrc) >>> shamt;
            aluOr:    aluResult = opA | opB;
            aluAnd:   aluResult = opA & opB;
            aluPassB: aluResult = opB;
            default:  aluResult = opA + opB;
        endcase
    end

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = {aluResult[63:1], 1'b0};  // rs1 + imm, bit 0 dropped
        end else if (ctrl.isJump || ctrl.branchTaken) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + 64'd4;
        end
    end

endmodule

/* source/coreSequencer.sv */
`timescale 1ns/1ps

module coreSequencer import rvPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    input  ctrlT    ctrl,
    input  xlenT    aluResult,
    input  addrT    nextPc,
    input  xlenT    rs2Val,
    output instT    inst,
    output addrT    pc,
    output xlenT    loadData,
    output logic    regWrite,
    output logic    wbCyc,
    output logic    wbStb,
    output logic    wbWe,
    output addrT    wbAdr,
    output xlenT    wbDatW,
    input  xlenT    wbDatR,
    output byteSelT wbSel,
    input  logic    wbAck,
    output logic    halted
);

    seqStateT   state;
    byteSelT    sizeMask;
    logic [2:0] addrLow;

    assign addrLow  = aluResult[2:0];
    assign regWrite = (state == stWrite) && ctrl.writeRd;
    assign halted   = (state == stHalt);

    always_comb begin
        case (ctrl.memSize)
            2'd0:    sizeMask = 8'h01;
            2'd1:    sizeMask = 8'h03;
            2'd2:    sizeMask = 8'h0f;
            default: sizeMask = 8'hff;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= stFetch;
            pc    <= resetPc;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe  <= 1'b0;
        end else begin
            case (state)
                stFetch: begin
                    if (!wbCyc) begin  // only on the first fetch out of reset
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                    end else if (wbAck) begin
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    if (ctrl.halt) begin
                        state <= stHalt;
                    end else if (ctrl.isLoad || ctrl.isStore) begin
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                        wbWe  <= ctrl.isStore;
                        state <= stMemory;
                    end else begin
                        state <= stWrite;
                    end
                end
                stMemory: begin
                    if (wbAck) begin
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        wbWe  <= 1'b0;
                        state <= stWrite;
                    end
                end
                stWrite: begin
                    pc    <= nextPc;
                    wbCyc <= 1'b1;  // next fetch starts right away
                    wbStb <= 1'b1;
                    state <= stFetch;
                end
                default: ;  // stHalt holds
            endcase
        end
    end

    // bus payload, loaded one cycle before each request
    always_ff @(posedge clock) begin
        case (state)
            stFetch: begin
                if (!wbCyc) begin
                    wbAdr <= {pc[63:3], 3'b000};
                    wbSel <= '1;
                end else if (wbAck) begin
                    inst <= pc[2] ? wbDatR[63:32] : wbDatR[31:0];
                end
            end
            stExecute: begin
                wbAdr  <= {aluResult[63:3], 3'b000};
                wbSel  <= ctrl.isStore ? byteSelT'(sizeMask << addrLow) : '1;
                wbDatW <= rs2Val << {addrLow, 3'b000};  // store data into its lane
            end
            stMemory: begin
                if (wbAck) begin
                    loadData <= wbDatR;
                end
            end
            stWrite: begin
                wbAdr <= {nextPc[63:3], 3'b000};
                wbSel <= '1;
            end
            default: ;
        endcase
    end

endmodule

/* source/instDecoder.sv */
`timescale 1ns/1ps

module instDecoder import rvPkg::*; (
    input  instT   inst,
    input  xlenT   rs1Val,
    input  xlenT   rs2Val,
    output ctrlT   ctrl,
    output xlenT   imm,
    output regIdxT rs1Idx,
    output regIdxT rs2Idx,
    output regIdxT rdIdx
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       regForm;
    logic       wordForm;
    aluOpT      arithOp;
    logic       arithLegal;
    logic       rsEq;
    logic       rsLt;
    logic       rsLtu;
    xlenT       immI;
    xlenT       immS;
    xlenT       immB;
    xlenT       immU;
    xlenT       immJ;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1Idx = inst[19:15];
    assign rs2Idx = inst[24:20];
    assign rdIdx  = inst[11:7];

    assign regForm  = (opcode == opReg) || (opcode == opReg32);
    assign wordForm = (opcode == opImm32) || (opcode == opReg32);

    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rsEq  = rs1Val == rs2Val;
    assign rsLt  = $signed(rs1Val) < $signed(rs2Val);
    assign rsLtu = rs1Val < rs2Val;

    // shared by OP, OP-IMM and their W forms
    always_comb begin
        arithLegal = 1'b1;
        case (funct3)
            3'b000:  arithOp = (regForm && funct7[5]) ? aluSub : aluAdd;
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b011:  arithOp = aluSltu;
            3'b100:  arithOp = aluXor;
            3'b101:  arithOp = funct7[5] ? aluSra : aluSrl;
            3'b110:  arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
        if (regForm) begin
            arithLegal = (funct7 == 7'h00) ||
                         (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (funct3 == 3'b001) begin
            arithLegal = funct7[6:1] == 6'h00;
        end else if (funct3 == 3'b101) begin
            arithLegal = (funct7[6:1] == 6'h00) || (funct7[6:1] == 6'h10);
        end
        if (wordForm && !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)) begin
            arithLegal = 1'b0;
        end
        if (wordForm && !regForm && funct3 != 3'b000 && funct7[0]) begin
            arithLegal = 1'b0;  // shamt[5] reserved in W shifts
        end
    end

    always_comb begin
        ctrl = '0;  // unknown encodings fall through as a nop
        imm  = immI;
        case (opcode)
            opLui: begin
                ctrl.aluOp   = aluPassB;
                ctrl.selB    = selImm;
                ctrl.writeRd = 1'b1;
                imm          = immU;
            end
            opAuipc: begin
                ctrl.selA    = selPc;
                ctrl.selB    = selImm;
                ctrl.writeRd = 1'b1;
                imm          = immU;
            end
            opJal: begin
                ctrl.writeRd = 1'b1;
                ctrl.wbSel   = wbLink;
                ctrl.isJump  = 1'b1;
                imm          = immJ;
            end
            opJalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.selA    = selRs1;
                    ctrl.selB    = selImm;  // target comes out of the alu
                    ctrl.writeRd = 1'b1;
                    ctrl.wbSel   = wbLink;
                    ctrl.isJump  = 1'b1;
                    ctrl.jumpReg = 1'b1;
                end
            end
            opBranch: begin
                imm = immB;
                case (funct3)
                    3'b000:  ctrl.branchTaken = rsEq;
                    3'b001:  ctrl.branchTaken = !rsEq;
                    3'b100:  ctrl.branchTaken = rsLt;
                    3'b101:  ctrl.branchTaken = !rsLt;
                    3'b110:  ctrl.branchTaken = rsLtu;
                    3'b111:  ctrl.branchTaken = !rsLtu;
                    default: ctrl.branchTaken = 1'b0;
                endcase
            end
            opLoad: begin
                if (funct3 != 3'b111) begin
                    ctrl.selB       = selImm;
                    ctrl.isLoad     = 1'b1;
                    ctrl.writeRd    = 1'b1;
                    ctrl.wbSel      = wbLoad;
                    ctrl.memSize    = funct3[1:0];
                    ctrl.loadSigned = !funct3[2];
                end
            end
            opStore: begin
                imm = immS;
                if (!funct3[2]) begin
                    ctrl.selB    = selImm;
                    ctrl.isStore = 1'b1;
                    ctrl.memSize = funct3[1:0];
                end
            end
            opImm, opImm32, opReg, opReg32: begin
                if (arithLegal) begin
                    ctrl.aluOp   = arithOp;
                    ctrl.selB    = regForm ? selRs2 : selImm;
                    ctrl.writeRd = 1'b1;
                    ctrl.word32  = wordForm;
                    ctrl.wbSel   = wordForm ? wbAluWord : wbAlu;
                end
            end
            opSystem: begin
                ctrl.halt = inst[31:7] == {12'h001, 13'h0};  // ebreak only
            end
            default: ;
        endcase
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic   clock,
    input  regIdxT rs1Idx,
    input  regIdxT rs2Idx,
    output xlenT   rs1Val,
    output xlenT   rs2Val,
    input  logic   writeEn,
    input  regIdxT rdIdx,
    input  xlenT   rdData
);

    xlenT regs [32];

    // x0 is never written, its read is forced to zero
    assign rs1Val = (rs1Idx == '0) ? '0 : regs[rs1Idx];
    assign rs2Val = (rs2Idx == '0) ? '0 : regs[rs2Idx];

    always_ff @(posedge clock) begin
        if (writeEn && rdIdx != '0) begin
            regs[rdIdx] <= rdData;
        end
    end

endmodule

/* source/resultSelect.sv */
`timescale 1ns/1ps

module resultSelect import rvPkg::*; (
    input  ctrlT       ctrl,
    input  xlenT       aluResult,
    input  addrT       pc,
    input  xlenT       loadData,
    input  logic [2:0] addrLow,
    output xlenT       rdData
);

    xlenT shifted;
    xlenT loadVal;

    assign shifted = loadData >> {addrLow, 3'b000};  // bring the lane down to byte 0

    always_comb begin
        case (ctrl.memSize)
            2'd0: begin
                loadVal = ctrl.loadSigned ? {{56{shifted[7]}}, shifted[7:0]}
                                          : {56'b0, shifted[7:0]};
            end
            2'd1: begin
                loadVal = ctrl.loadSigned ? {{48{shifted[15]}}, shifted[15:0]}
                                          : {48'b0, shifted[15:0]};
            end
            2'd2: begin
                loadVal = ctrl.loadSigned ? {{32{shifted[31]}}, shifted[31:0]}
                                          : {32'b0, shifted[31:0]};
            end
            default: loadVal = shifted;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            wbAlu:     rdData = aluResult;
            wbLoad:    rdData = loadVal;
            wbLink:    rdData = pc + 64'd4;  // pc still holds the current instruction
            wbAluWord: rdData = {{32{aluResult[31]}}, aluResult[31:0]};
            default:   rdData = aluResult;
        endcase
    end

endmodule

/* source/rvCore.sv */
`timescale 1ns/1ps

module rvCore import rvPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    output logic    wbCyc,
    output logic    wbStb,
    output logic    wbWe,
    output addrT    wbAdr,
    output xlenT    wbDatW,
    input  xlenT    wbDatR,
    output byteSelT wbSel,
    input  logic    wbAck,
    output logic    halted
);

    instT   inst;
    ctrlT   ctrl;
    xlenT   imm;
    regIdxT rs1Idx;
    regIdxT rs2Idx;
    regIdxT rdIdx;
    xlenT   rs1Val;
    xlenT   rs2Val;
    xlenT   aluResult;
    addrT   nextPc;
    addrT   pc;
    xlenT   loadData;
    xlenT   rdData;
    logic   regWrite;

    instDecoder decoder (
        .inst   (inst),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .ctrl   (ctrl),
        .imm    (imm),
        .rs1Idx (rs1Idx),
        .rs2Idx (rs2Idx),
        .rdIdx  (rdIdx)
    );

    aluExecute execute (
        .ctrl      (ctrl),
        .pc        (pc),
        .imm       (imm),
        .rs1Val    (rs1Val),
        .rs2Val    (rs2Val),
        .aluResult (aluResult),
        .nextPc    (nextPc)
    );

    resultSelect result (
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .pc        (pc),
        .loadData  (loadData),
        .addrLow   (aluResult[2:0]),  // byte offset of the load address
        .rdData    (rdData)
    );

    regFile regs (
        .clock   (clock),
        .rs1Idx  (rs1Idx),
        .rs2Idx  (rs2Idx),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val),
        .writeEn (regWrite),
        .rdIdx   (rdIdx),
        .rdData  (rdData)
    );

    coreSequencer sequencer (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .nextPc    (nextPc),
        .rs2Val    (rs2Val),
        .inst      (inst),
        .pc        (pc),
        .loadData  (loadData),
        .regWrite  (regWrite),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbSel     (wbSel),
        .wbAck     (wbAck),
        .halted    (halted)
    );

endmodule

/* source/rvPkg.sv */
package rvPkg;

    typedef logic [63:0] xlenT;
    typedef logic [31:0] instT;
    typedef logic [63:0] addrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [7:0]  byteSelT;
    typedef logic [6:0]  opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpT;

    typedef enum logic [1:0] {
        wbAlu,
        wbLoad,
        wbLink,
        wbAluWord  // low word, sign extended
    } wbSelT;

    typedef enum logic [2:0] {
        stFetch,
        stExecute,
        stMemory,
        stWrite,
        stHalt
    } seqStateT;

    typedef struct packed {
        aluOpT      aluOp;
        logic       selA;         // rs1 or pc
        logic       selB;         // rs2 or imm
        logic       writeRd;
        wbSelT      wbSel;
        logic       isLoad;
        logic       isStore;
        logic [1:0] memSize;      // log2 of byte count
        logic       loadSigned;
        logic       word32;       // W forms
        logic       isJump;
        logic       jumpReg;      // jalr
        logic       branchTaken;
        logic       halt;
    } ctrlT;

    localparam addrT resetPc = 64'h0;

    localparam logic selRs1 = 1'b0;
    localparam logic selPc  = 1'b1;
    localparam logic selRs2 = 1'b0;
    localparam logic selImm = 1'b1;

    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opImm32  = 7'b0011011;
    localparam opcodeT opReg    = 7'b0110011;
    localparam opcodeT opReg32  = 7'b0111011;
    localparam opcodeT opSystem = 7'b1110011;

endpackage
